// File: hdl/ttlCore_defs.svh
`ifndef TTLCORE_DEFS_SVH
`define TTLCORE_DEFS_SVH

// Width of the data bus and both operand registers
`define DATA_WIDTH 8

`define SEQ_STEPS 2   // Start edge to A load edge

`endif

// File: hdl/aluPkg.sv
`include "ttlCore_defs.svh"

package aluPkg;

   typedef logic [`DATA_WIDTH-1:0] busWordT;   // One word on the data bus

   // Carry and shift flags together, for checking
   typedef struct packed {
      logic carry;
      logic shift;
   } flagPairT;

endpackage

// File: hdl/ctrlPkg.sv
package ctrlPkg;

   // Instruction set of the accumulator datapath
   typedef enum logic [2:0] {
      LDA = 3'd0,
      ADD = 3'd1,
      SUB = 3'd2,
      ADC = 3'd3,
      SBC = 3'd4,
      SHR = 3'd5,
      RCR = 3'd6
   } opcodeT;

   typedef enum logic [1:0] {
      IDLE  = 2'd0,   // Waiting for start
      LOADB = 2'd1,   // Operand into B
      EXEC  = 2'd2    // Result into A, flags clocked
   } seqStateT;

endpackage

// File: hdl/aluNet.sv
`timescale 1ns/1ps
`include "ttlCore_defs.svh"

module aluNet import aluPkg::*; (
   input  logic    clk,
   input  logic    rst,
   input  logic    doSubtract,
   input  logic    doCarryIn,
   input  logic    doShiftIn,
   input  logic    enAlu,
   input  logic    enShift,
   input  logic    triggerC,
   input  logic    triggerS,
   input  busWordT areg,
   input  busWordT breg,
   output busWordT aluBus,
   output logic    aIsZero,
   output logic    flagCarry,
   output logic    flagShift
);

   busWordT              other;
   logic                 cin;
   logic [`DATA_WIDTH:0] sum;
   busWordT              shifted;
   logic                 shiftIn;

   assign other = breg ^ {`DATA_WIDTH{doSubtract}};   // Invert B for subtract

   // Carry flag acts as not-borrow when chaining a subtract
   assign cin = doCarryIn ? flagCarry : doSubtract;

   assign sum = {1'b0, areg} + {1'b0, other} + {{`DATA_WIDTH{1'b0}}, cin};

   assign shiftIn = flagShift & doShiftIn;
   assign shifted = {shiftIn, areg[`DATA_WIDTH-1:1]};

   // Each source is zero unless enabled, so the bus is a plain OR
   assign aluBus = (enAlu ? sum[`DATA_WIDTH-1:0] : '0) |
                   (enShift ? shifted : '0);

   assign aIsZero = (areg == '0);

   always_ff @(posedge clk) begin
      if (rst) begin
         flagCarry <= 1'b0;
         flagShift <= 1'b0;
      end else begin
         if (triggerC) begin
            flagCarry <= sum[`DATA_WIDTH];   // Adder carry out
         end
         if (triggerS) begin
            flagShift <= areg[0];            // Bit shifted out
         end
      end
   end

   // Sequencer must never drive both ALU sources at once
   aluOneSource: assert property (
      @(posedge clk) disable iff (rst)
      !(enAlu && enShift)
   );

   // A flag is only clocked while its result is on the bus
   flagWithSource: assert property (
      @(posedge clk) disable iff (rst)
      (triggerC |-> enAlu) and (triggerS |-> enShift)
   );

endmodule

// File: hdl/operandRegs.sv
`timescale 1ns/1ps

module operandRegs import aluPkg::*; (
   input  logic    clk,
   input  logic    rst,
   input  logic    enOperand,
   input  logic    loadA,
   input  logic    loadB,
   input  busWordT operand,
   input  busWordT aluBus,
   output busWordT dbus,
   output busWordT areg,
   output busWordT breg
);

   // Bus merge of ALU result and instruction operand
   assign dbus = aluBus | (enOperand ? operand : '0);

   always_ff @(posedge clk) begin
      if (rst) begin
         areg <= '0;
         breg <= '0;
      end else begin
         if (loadA) begin
            areg <= dbus;   // Accumulator
         end
         if (loadB) begin
            breg <= dbus;
         end
      end
   end

   // Operand and ALU must not share the bus
   busNoClash: assert property (
      @(posedge clk) disable iff (rst)
      enOperand |-> (aluBus == '0)
   );

   oneLoad: assert property (
      @(posedge clk) disable iff (rst)
      !(loadA && loadB)
   );

   // B loads only in the step before A loads
   loadOrder: assert property (
      @(posedge clk) disable iff (rst)
      loadB |=> loadA
   );

endmodule

// File: hdl/microSeq.sv
`timescale 1ns/1ps
`include "ttlCore_defs.svh"

module microSeq import ctrlPkg::*; (
   input  logic   clk,
   input  logic   rst,
   input  logic   start,
   input  opcodeT op,
   output logic   doSubtract,
   output logic   doCarryIn,
   output logic   doShiftIn,
   output logic   enAlu,
   output logic   enShift,
   output logic   triggerC,
   output logic   triggerS,
   output logic   enOperand,
   output logic   loadA,
   output logic   loadB,
   output logic   busy,
   output logic   done
);

   seqStateT state;
   seqStateT stateNext;
   opcodeT   opReg;

   always_comb begin
      stateNext = state;
      case (state)
         IDLE: begin
            if (start) begin
               stateNext = LOADB;
            end
         end
         LOADB: begin
            stateNext = EXEC;
         end
         EXEC: begin
            stateNext = IDLE;
         end
         default: begin
            stateNext = IDLE;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= IDLE;
         opReg <= LDA;
         done  <= 1'b0;
      end else begin
         state <= stateNext;
         done  <= (state == EXEC);   // One cycle after A loads
         if (state == IDLE && start) begin
            opReg <= op;             // Starts while busy are dropped
         end
      end
   end

   assign busy = (state != IDLE);

   // Control word for the current step
   always_comb begin
      doSubtract = 1'b0;
      doCarryIn  = 1'b0;
      doShiftIn  = 1'b0;
      enAlu      = 1'b0;
      enShift    = 1'b0;
      triggerC   = 1'b0;
      triggerS   = 1'b0;
      enOperand  = 1'b0;
      loadA      = 1'b0;
      loadB      = 1'b0;
      case (state)
         LOADB: begin
            enOperand = 1'b1;
            loadB     = 1'b1;
         end
         EXEC: begin
            loadA = 1'b1;
            case (opReg)
               LDA: begin
                  enOperand = 1'b1;
               end
               ADD: begin
                  enAlu    = 1'b1;
                  triggerC = 1'b1;
               end
               SUB: begin
                  enAlu      = 1'b1;
                  doSubtract = 1'b1;
                  triggerC   = 1'b1;
               end
               ADC: begin
                  enAlu     = 1'b1;
                  doCarryIn = 1'b1;
                  triggerC  = 1'b1;
               end
               SBC: begin
                  enAlu      = 1'b1;
                  doSubtract = 1'b1;
                  doCarryIn  = 1'b1;
                  triggerC   = 1'b1;
               end
               SHR: begin
                  enShift  = 1'b1;
                  triggerS = 1'b1;
               end
               RCR: begin
                  enShift   = 1'b1;
                  doShiftIn = 1'b1;
                  triggerS  = 1'b1;
               end
               default: begin
                  loadA = 1'b0;   // Unused code, A kept
               end
            endcase
         end
         default: begin
         end
      endcase
   end

   donePulse: assert property (
      @(posedge clk) disable iff (rst)
      done |=> !done
   );

   noLoadIdle: assert property (
      @(posedge clk) disable iff (rst)
      (state == IDLE) |-> !(loadA || loadB)
   );

   // Accepted start reaches the A load and then done on fixed edges
   startToDone: assert property (
      @(posedge clk) disable iff (rst)
      (start && !busy) |-> ##(`SEQ_STEPS) (loadA ##1 done)
   );

endmodule

// File: hdl/ttlCore.sv
`timescale 1ns/1ps

module ttlCore
   import aluPkg::*;
   import ctrlPkg::*;
(
   input  logic    clk,
   input  logic    rst,
   input  logic    start,
   input  opcodeT  op,
   input  busWordT operand,
   output busWordT accA,
   output logic    flagCarry,
   output logic    flagShift,
   output logic    aIsZero,
   output logic    busy,
   output logic    done
);

   // ALU controls
   logic doSubtract;
   logic doCarryIn;
   logic doShiftIn;
   logic enAlu;
   logic enShift;
   logic triggerC;
   logic triggerS;

   // Register controls
   logic enOperand;
   logic loadA;
   logic loadB;

   busWordT aluBus;
   busWordT breg;

   microSeq uSeq (
      .clk        (clk),
      .rst        (rst),
      .start      (start),
      .op         (op),
      .doSubtract (doSubtract),
      .doCarryIn  (doCarryIn),
      .doShiftIn  (doShiftIn),
      .enAlu      (enAlu),
      .enShift    (enShift),
      .triggerC   (triggerC),
      .triggerS   (triggerS),
      .enOperand  (enOperand),
      .loadA      (loadA),
      .loadB      (loadB),
      .busy       (busy),
      .done       (done)
   );

   operandRegs uRegs (
      .clk       (clk),
      .rst       (rst),
      .enOperand (enOperand),
      .loadA     (loadA),
      .loadB     (loadB),
      .operand   (operand),
      .aluBus    (aluBus),
      .dbus      (),          // Merged bus stays internal
      .areg      (accA),
      .breg      (breg)
   );

   aluNet uAlu (
      .clk        (clk),
      .rst        (rst),
      .doSubtract (doSubtract),
      .doCarryIn  (doCarryIn),
      .doShiftIn  (doShiftIn),
      .enAlu      (enAlu),
      .enShift    (enShift),
      .triggerC   (triggerC),
      .triggerS   (triggerS),
      .areg       (accA),
      .breg       (breg),
      .aluBus     (aluBus),
      .aIsZero    (aIsZero),
      .flagCarry  (flagCarry),
      .flagShift  (flagShift)
   );

endmodule

// File: dv/ttlCoreTb.sv
`timescale 1ns/1ps
`include "ttlCore_defs.svh"

module ttlCoreTb
   import aluPkg::*;
   import ctrlPkg::*;
();

   localparam int CLK_PERIOD      = 20;
   localparam int NUM_INSTR       = 233;   // Instructions issued over all tests
   localparam int WATCHDOG_CYCLES = NUM_INSTR * (`SEQ_STEPS + 4) + 50;
   localparam int WORD_RANGE      = 1 << `DATA_WIDTH;

   logic    clk = 1'b0;
   logic    rst;
   logic    start;
   opcodeT  op;
   busWordT operand;
   busWordT accA;
   logic    flagCarry;
   logic    flagShift;
   logic    aIsZero;
   logic    busy;
   logic    done;

   // Reference model of A and the flags
   busWordT modelA;
   logic    modelC;
   logic    modelS;

   logic [31:0] lcgState = 32'h22d6;
   logic        lastBusy;
   int          lastEdges;
   int          checks;
   int          errors;
   int          testErrors;
   int          testsRun;
   int          testsFailed;

   ttlCore UUT (
      .clk       (clk),
      .rst       (rst),
      .start     (start),
      .op        (op),
      .operand   (operand),
      .accA      (accA),
      .flagCarry (flagCarry),
      .flagShift (flagShift),
      .aIsZero   (aIsZero),
      .busy      (busy),
      .done      (done)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   function automatic logic [31:0] nextRand();
      lcgState = lcgState * 32'd1664525 + 32'd1013904223;
      return lcgState;
   endfunction

   task automatic noteError();
      errors++;
      testErrors++;
   endtask

   task automatic compareWord(input string name, input busWordT got, input busWordT exp);
      checks++;
      if (got !== exp) begin
         noteError();
         $display("FAIL %s got 0x%h expected 0x%h", name, got, exp);
      end
   endtask

   task automatic compareFlags(input string name, input flagPairT got, input flagPairT exp);
      checks++;
      if (got !== exp) begin
         noteError();
         $display("FAIL %s got 0x%h expected 0x%h", name, got, exp);
      end
   endtask

   task automatic compareBit(input string name, input logic got, input logic exp);
      checks++;
      if (got !== exp) begin
         noteError();
         $display("FAIL %s got 0x%h expected 0x%h", name, got, exp);
      end
   endtask

   task automatic checkState();
      compareWord("accA", accA, modelA);
      compareFlags("flags", {flagCarry, flagShift}, {modelC, modelS});
      compareBit("aIsZero", aIsZero, modelA == '0);
   endtask

   // Expected A and flags from the instruction table
   task automatic applyModel(input opcodeT code, input busWordT value);
      int wide;
      case (code)
         LDA: modelA = value;
         ADD, ADC: begin
            wide   = int'(modelA) + int'(value) + ((code == ADC && modelC) ? 1 : 0);
            modelC = (wide >= WORD_RANGE);
            modelA = busWordT'(wide);
         end
         SUB, SBC: begin
            wide   = int'(modelA) - int'(value) - ((code == SBC && !modelC) ? 1 : 0);
            modelC = (wide >= 0);   // Set when nothing was borrowed
            modelA = busWordT'(wide);
         end
         default: begin
            wide   = (code == RCR) ? int'(modelS) : 0;   // Bit entering at the top
            modelS = modelA[0];
            modelA = {wide[0], modelA[`DATA_WIDTH-1:1]};
         end
      endcase
   endtask

   // One instruction, then wait for its done pulse
   task automatic issue(input opcodeT code, input busWordT value);
      @(negedge clk);
      start   = 1'b1;
      op      = code;
      operand = value;
      @(negedge clk);
      start     = 1'b0;
      lastBusy  = busy;
      lastEdges = 0;
      while (!done && lastEdges < `SEQ_STEPS + 2) begin
         @(negedge clk);
         lastEdges++;
      end
      if (!done) begin
         noteError();
         $display("Error: no done pulse within %0d cycles of a %s start",
                  lastEdges + 1, code.name());
      end
      applyModel(code, value);
      checkState();
   endtask

   task automatic finishTest(input string name);
      testsRun++;
      if (testErrors != 0) begin
         testsFailed++;
      end
      $display("Test %-10s %s, %0d errors", name, (testErrors == 0) ? "ok" : "bad", testErrors);
      testErrors = 0;
   endtask

   task automatic testResetLda();
      compareWord("accA", accA, '0);
      compareFlags("flags", {flagCarry, flagShift}, 2'b00);
      compareBit("aIsZero", aIsZero, 1'b1);
      compareBit("busy", busy, 1'b0);
      compareBit("done", done, 1'b0);
      issue(LDA, 8'h5A);
      compareBit("busy", lastBusy, 1'b1);
      if (lastEdges != `SEQ_STEPS) begin
         noteError();
         $display("Error: done came %0d edges after start instead of %0d",
                  lastEdges, `SEQ_STEPS);
      end
      @(negedge clk);
      compareBit("done", done, 1'b0);   // Single cycle pulse
      finishTest("resetLda");
   endtask

   task automatic testAddSub();
      issue(LDA, 8'h01);
      issue(SHR, 8'h00);   // Shift flag now 1
      issue(LDA, 8'h3C);
      issue(ADD, 8'h55);
      issue(LDA, 8'hF0);
      issue(ADD, 8'h20);   // Overflow
      issue(LDA, 8'h40);
      issue(SUB, 8'h10);
      issue(LDA, 8'h10);
      issue(SUB, 8'h40);   // Borrow
      finishTest("addSub");
   endtask

   task automatic testChain16();
      int x;
      int y;
      int r;
      x = 'h12F0;
      y = 'h34A5;
      r = x + y;
      issue(LDA, busWordT'(x));
      issue(ADD, busWordT'(y));
      issue(LDA, busWordT'(x >> `DATA_WIDTH));   // Carry must survive this load
      issue(ADC, busWordT'(y >> `DATA_WIDTH));
      compareWord("sumHigh", accA, busWordT'(r >> `DATA_WIDTH));
      compareBit("flagCarry", flagCarry, r >= 'h10000);
      x = 'h5210;
      y = 'h1730;
      r = x - y;
      issue(LDA, busWordT'(x));
      issue(SUB, busWordT'(y));
      issue(LDA, busWordT'(x >> `DATA_WIDTH));
      issue(SBC, busWordT'(y >> `DATA_WIDTH));
      compareWord("diffHigh", accA, busWordT'(r >> `DATA_WIDTH));
      compareBit("flagCarry", flagCarry, r >= 0);
      finishTest("chain16");
   endtask

   task automatic testShifts();
      opcodeT shiftOps[6] = '{SHR, RCR, RCR, SHR, RCR, RCR};
      issue(LDA, 8'hF0);
      issue(ADD, 8'h20);   // Carry set before the shifts
      issue(LDA, 8'hA5);
      foreach (shiftOps[i]) begin
         issue(shiftOps[i], 8'h00);
      end
      finishTest("shifts");
   endtask

   task automatic testZeroBusy();
      int edges;
      issue(LDA, 8'h77);
      issue(SUB, 8'h77);
      issue(LDA, 8'h33);
      issue(LDA, 8'h00);
      @(negedge clk);
      start   = 1'b1;
      op      = LDA;
      operand = 8'h44;
      @(negedge clk);
      op    = SHR;   // Start stays high through LOADB and EXEC
      edges = 0;
      while (!done && edges < `SEQ_STEPS + 2) begin
         @(negedge clk);
         edges++;
      end
      start = 1'b0;
      compareBit("done", done, 1'b1);
      applyModel(LDA, 8'h44);
      checkState();
      repeat (3) begin
         @(negedge clk);
         compareBit("done", done, 1'b0);
         compareBit("busy", busy, 1'b0);
      end
      finishTest("zeroBusy");
   endtask

   task automatic testRandom();
      logic [31:0] r;
      logic [2:0]  code;
      int          i;
      for (i = 0; i < 200; i++) begin
         r    = nextRand();
         code = 3'(r[31:16] % 16'd7);
         issue(opcodeT'(code), r[`DATA_WIDTH+7:8]);
      end
      finishTest("random");
   endtask

   initial begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("Watchdog expired after %0d cycles before the tests ended", WATCHDOG_CYCLES);
      $display("Some tests failed");
      $finish;
   end

   initial begin
      rst     = 1'b1;
      start   = 1'b0;
      op      = LDA;
      operand = '0;
      modelA  = '0;
      modelC  = 1'b0;
      modelS  = 1'b0;
      repeat (5) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      testResetLda();
      testAddSub();
      testChain16();
      testShifts();
      testZeroBusy();
      testRandom();
      $display("Tests %0d, failed %0d, checks %0d, errors %0d",
               testsRun, testsFailed, checks, errors);
      if (errors == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule

// File: ttlCore.f
+incdir+hdl
hdl/aluPkg.sv
hdl/ctrlPkg.sv
hdl/aluNet.sv
hdl/operandRegs.sv
hdl/microSeq.sv
hdl/ttlCore.sv
dv/ttlCoreTb.sv

// File: run.sh
#!/bin/sh
# Compile and simulate the ttlCore testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ps -f ttlCore.f --top-module ttlCoreTb
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/VttlCoreTb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "Some tests failed" sim.log; then
   echo "Simulation reported failures"
   exit 1
fi

echo "Simulation clean"
exit 0
